// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

  // cause register width and interrupt id width, fixed by the ISA
  localparam int CAUSE_W  = 6;
  localparam int IRQ_ID_W = 5;

  // synchronous exception codes, msb clear marks an exception
  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL = 6'h02;
  localparam logic [CAUSE_W-1:0] CAUSE_ECALL_M = 6'h0b;

  // main controller states
  typedef enum logic [4:0] {
    RESET, BOOT_SET, WAIT_SLEEP, SLEEP, FIRST_FETCH, DECODE,
    FLUSH_EX, FLUSH_WB, IRQ_FLUSH, IRQ_TAKEN_ID, IRQ_TAKEN_IF
  } ctrl_state_e;

  // next pc source in the fetch stage
  typedef enum logic [2:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_ERET      = 3'b101
  } pc_mux_e;

  // vector table entry for exceptions
  typedef enum logic [1:0] {
    EXC_PC_ILLINSN = 2'b00,
    EXC_PC_ECALL   = 2'b01,
    EXC_PC_IRQ     = 2'b11
  } exc_pc_e;

  // kind of control transfer seen by the decoder
  typedef enum logic [1:0] {
    JUMP_NONE = 2'b00,
    JUMP_JAL  = 2'b01,
    JUMP_JALR = 2'b10,
    JUMP_COND = 2'b11
  } jump_e;

  // decoder flags that force a pipe flush
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic pipe_flush;
  } decode_t;

  // level interrupt request with its id
  typedef struct packed {
    logic                req;
    logic [IRQ_ID_W-1:0] id;
  } irq_t;

  // trap side effects requested by the FSM
  typedef struct packed {
    logic               save_cause;
    logic [CAUSE_W-1:0] cause;
    logic               restore_mret;
  } trap_upd_t;

  // software write of the machine interrupt enable
  typedef struct packed {
    logic we;
    logic mie;
  } csr_wr_t;

endpackage

// File: rtl/hazard_pkg.sv
package hazard_pkg;

  // operand source in the ID stage
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

  // one select per source operand
  typedef struct packed {
    fwd_sel_e sel_a;
    fwd_sel_e sel_b;
    fwd_sel_e sel_c;
  } fwd_sel_t;

  // producer destination equals source operand a, b or c
  typedef struct packed {
    logic a;
    logic b;
    logic c;
  } reg_match_t;

  // register file write enables of the producer stages
  typedef struct packed {
    logic ex;
    logic wb;
    logic alu_fw;
  } wr_en_t;

endpackage

// File: rtl/trap_csr.sv
`timescale 1ns/1ns

module trap_csr (
  input  logic                         clk,
  input  logic                         rst_n,
  input  ctrl_pkg::csr_wr_t            csr_wr_i,
  input  ctrl_pkg::trap_upd_t          trap_upd_i,
  output logic                         irq_en_o,
  output logic [ctrl_pkg::CAUSE_W-1:0] mcause_o
);

  logic                         mie_q;
  logic                         mpie_q;
  logic [ctrl_pkg::CAUSE_W-1:0] mcause_q;

  // trap updates win over a software write in the same cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mcause_q <= '0;
    end
    else if (trap_upd_i.save_cause)
    begin
      // trap entry stacks the enable and masks further interrupts
      mcause_q <= trap_upd_i.cause;
      mpie_q   <= mie_q;
      mie_q    <= 1'b0;
    end
    else if (trap_upd_i.restore_mret)
    begin
      // mret pops the enable, mpie goes back to 1 per the spec
      mie_q    <= mpie_q;
      mpie_q   <= 1'b1;
    end
    else if (csr_wr_i.we)
    begin
      mie_q    <= csr_wr_i.mie;
    end
  end

  // the FSM gates interrupt entry with this
  assign irq_en_o = mie_q;
  assign mcause_o = mcause_q;

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ns

module hazard_unit (
  input  logic                   is_decoding_i,
  input  ctrl_pkg::decode_t      decode_i,
  input  ctrl_pkg::jump_e        jump_dec_i,
  input  logic                   data_req_ex_i,
  input  logic                   wb_ready_i,
  input  logic                   data_misaligned_i,
  input  hazard_pkg::wr_en_t     wr_en_i,
  input  hazard_pkg::reg_match_t match_ex_i,
  input  hazard_pkg::reg_match_t match_wb_i,
  input  hazard_pkg::reg_match_t match_alu_i,
  output logic                   load_stall_o,
  output logic                   jr_stall_o,
  output logic                   misaligned_stall_o,
  output logic                   deassert_we_o
);

  logic load_ex_hit;
  logic wb_busy_hit;

  // load data in EX is not back yet
  assign load_ex_hit = data_req_ex_i & wr_en_i.ex & (|match_ex_i);
  // WB holds a write that cannot retire this cycle
  assign wb_busy_hit = ~wb_ready_i & wr_en_i.wb & (|match_wb_i);

  always_comb
  begin
    load_stall_o = load_ex_hit | wb_busy_hit;

    // jalr target comes from operand a, no forwarding into the pc path
    jr_stall_o = (jump_dec_i == ctrl_pkg::JUMP_JALR) &&
                 ((wr_en_i.wb     & match_wb_i.a) ||
                  (wr_en_i.ex     & match_ex_i.a) ||
                  (wr_en_i.alu_fw & match_alu_i.a));

    // instruction in ID must not write while stalled or not issued
    deassert_we_o = ~is_decoding_i | decode_i.illegal | load_stall_o | jr_stall_o;
  end

  // second half of a misaligned access occupies EX
  assign misaligned_stall_o = data_misaligned_i;

endmodule

// File: rtl/fwd_unit.sv
`timescale 1ns/1ns

module fwd_unit (
  input  hazard_pkg::wr_en_t     wr_en_i,
  input  hazard_pkg::reg_match_t match_wb_i,
  input  hazard_pkg::reg_match_t match_alu_i,
  input  logic                   data_misaligned_i,
  input  logic                   mult_multicycle_i,
  output hazard_pkg::fwd_sel_t   fwd_sel_o
);

  // younger EX result beats the WB result
  function automatic hazard_pkg::fwd_sel_e fwd_pick(input logic wb_hit, input logic alu_hit);
    hazard_pkg::fwd_sel_e sel;
    sel = hazard_pkg::SEL_REGFILE;
    if (wb_hit)
      sel = hazard_pkg::SEL_FW_WB;
    if (alu_hit)
      sel = hazard_pkg::SEL_FW_EX;
    return sel;
  endfunction

  always_comb
  begin
    fwd_sel_o.sel_a = fwd_pick(wr_en_i.wb & match_wb_i.a, wr_en_i.alu_fw & match_alu_i.a);
    fwd_sel_o.sel_b = fwd_pick(wr_en_i.wb & match_wb_i.b, wr_en_i.alu_fw & match_alu_i.b);
    fwd_sel_o.sel_c = fwd_pick(wr_en_i.wb & match_wb_i.c, wr_en_i.alu_fw & match_alu_i.c);

    if (data_misaligned_i)
    begin
      // second access reuses the address from EX
      fwd_sel_o.sel_a = hazard_pkg::SEL_FW_EX;
      fwd_sel_o.sel_b = hazard_pkg::SEL_REGFILE;
    end
    else if (mult_multicycle_i)
    begin
      // multiplier keeps its partial result on operand c
      fwd_sel_o.sel_c = hazard_pkg::SEL_FW_EX;
    end
  end

endmodule

// File: rtl/ctrl_fsm.sv
`timescale 1ns/1ns

module ctrl_fsm (
  input  logic                clk,
  input  logic                rst_n,

  // core enable and instruction from IF/ID
  input  logic                fetch_en_i,
  input  logic                instr_valid_i,
  input  ctrl_pkg::decode_t   decode_i,
  input  ctrl_pkg::jump_e     jump_dec_i,
  input  ctrl_pkg::jump_e     jump_id_i,
  input  logic                branch_taken_i,

  // pipeline handshakes
  input  logic                id_ready_i,
  input  logic                ex_valid_i,

  // interrupt request and enable from the trap block
  input  ctrl_pkg::irq_t      irq_i,
  input  logic                irq_en_i,
  input  logic                jr_stall_i,

  output logic                instr_req_o,
  output logic                busy_o,
  output logic                pc_set_o,
  output ctrl_pkg::pc_mux_e   pc_mux_o,
  output ctrl_pkg::exc_pc_e   exc_pc_mux_o,
  output logic                halt_if_o,
  output logic                halt_id_o,
  output logic                irq_ack_o,
  output logic                is_decoding_o,
  output ctrl_pkg::trap_upd_t trap_upd_o
);

  ctrl_pkg::ctrl_state_e state_q, state_d;
  logic jump_done_q, jump_done_d;
  logic irq_take;
  logic jump_in_dec;
  logic branch_redirect;
  logic flush_insn;

  // interrupt is only taken while mie is set
  assign irq_take        = irq_i.req & irq_en_i;
  // jal and jalr targets are known in decode
  assign jump_in_dec     = (jump_dec_i == ctrl_pkg::JUMP_JAL) ||
                           (jump_dec_i == ctrl_pkg::JUMP_JALR);
  // taken conditional branch resolved behind the decoded instruction
  assign branch_redirect = branch_taken_i & (jump_id_i == ctrl_pkg::JUMP_COND);
  assign flush_insn      = |decode_i;

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////

  always_comb
  begin
    state_d       = state_q;
    jump_done_d   = jump_done_q;
    instr_req_o   = 1'b1;
    busy_o        = 1'b1;
    pc_set_o      = 1'b0;
    pc_mux_o      = ctrl_pkg::PC_BOOT;
    exc_pc_mux_o  = ctrl_pkg::EXC_PC_IRQ;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    irq_ack_o     = 1'b0;
    is_decoding_o = 1'b0;
    trap_upd_o    = '0;

    unique case (state_q)
      // idle until the core gets enabled
      ctrl_pkg::RESET:
      begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        if (fetch_en_i)
          state_d = ctrl_pkg::BOOT_SET;
      end

      // load boot address into the prefetcher, one cycle
      ctrl_pkg::BOOT_SET:
      begin
        pc_set_o = 1'b1;
        pc_mux_o = ctrl_pkg::PC_BOOT;
        state_d  = ctrl_pkg::FIRST_FETCH;
      end

      // one cycle to let fetch settle before sleeping
      ctrl_pkg::WAIT_SLEEP:
      begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = ctrl_pkg::SLEEP;
      end

      // wake on enable or on any pending request, even masked
      ctrl_pkg::SLEEP:
      begin
        busy_o      = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (fetch_en_i || irq_i.req)
          state_d = ctrl_pkg::FIRST_FETCH;
      end

      ctrl_pkg::FIRST_FETCH:
      begin
        // wait out the IF miss
        if (id_ready_i)
          state_d = ctrl_pkg::DECODE;
        // pipeline is empty here so the irq goes straight in
        if (irq_take)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = ctrl_pkg::IRQ_TAKEN_IF;
        end
      end

      ctrl_pkg::DECODE:
      begin
        if (branch_redirect)
        begin
          // instruction in ID is on the wrong path
          pc_set_o = 1'b1;
          pc_mux_o = ctrl_pkg::PC_BRANCH;
        end
        else if (instr_valid_i)
        begin
          is_decoding_o = 1'b1;
          if (irq_take)
          begin
            // let EX drain before redirecting
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::IRQ_FLUSH;
          end
          else if (jump_in_dec)
          begin
            pc_mux_o = ctrl_pkg::PC_JUMP;
            // only one redirect per jump, held off by a jr stall
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_set_o    = 1'b1;
              jump_done_d = 1'b1;
            end
          end
          else if (flush_insn)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = ctrl_pkg::FLUSH_EX;
          end
        end
      end

      // wait for EX to finish the older instruction
      ctrl_pkg::FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = ctrl_pkg::FLUSH_WB;
      end

      // recheck, mie may have been cleared by the draining instruction
      ctrl_pkg::IRQ_FLUSH:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (irq_take)
          state_d = ctrl_pkg::IRQ_TAKEN_ID;
        else
          state_d = ctrl_pkg::DECODE;
      end

      // jump to the irq vector, ack lets the source drop req
      ctrl_pkg::IRQ_TAKEN_ID, ctrl_pkg::IRQ_TAKEN_IF:
      begin
        pc_set_o              = 1'b1;
        pc_mux_o              = ctrl_pkg::PC_EXCEPTION;
        exc_pc_mux_o          = ctrl_pkg::EXC_PC_IRQ;
        irq_ack_o             = 1'b1;
        trap_upd_o.save_cause = 1'b1;
        trap_upd_o.cause      = {1'b1, irq_i.id};
        state_d               = ctrl_pkg::DECODE;
      end

      // EX and WB are clear, the trap instruction is still in ID
      ctrl_pkg::FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (decode_i.illegal)
        begin
          pc_set_o              = 1'b1;
          pc_mux_o              = ctrl_pkg::PC_EXCEPTION;
          exc_pc_mux_o          = ctrl_pkg::EXC_PC_ILLINSN;
          trap_upd_o.save_cause = 1'b1;
          trap_upd_o.cause      = ctrl_pkg::CAUSE_ILLEGAL;
        end
        else if (decode_i.ecall)
        begin
          pc_set_o              = 1'b1;
          pc_mux_o              = ctrl_pkg::PC_EXCEPTION;
          exc_pc_mux_o          = ctrl_pkg::EXC_PC_ECALL;
          trap_upd_o.save_cause = 1'b1;
          trap_upd_o.cause      = ctrl_pkg::CAUSE_ECALL_M;
        end
        else if (decode_i.mret)
        begin
          pc_set_o                = 1'b1;
          pc_mux_o                = ctrl_pkg::PC_ERET;
          trap_upd_o.restore_mret = 1'b1;
        end
        // mret or fence-style flush with the core disabled goes to sleep
        if (!fetch_en_i && (decode_i.mret || decode_i.pipe_flush))
          state_d = ctrl_pkg::WAIT_SLEEP;
        else
          state_d = ctrl_pkg::DECODE;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = ctrl_pkg::RESET;
      end
    endcase
  end

  ////////////////////////////////////////
  // state registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= ctrl_pkg::RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // jump leaves ID once id_ready is seen
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

endmodule

// File: rtl/core_ctrl.sv
`timescale 1ns/1ns

module core_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,

  // decode side
  input  logic                         fetch_en_i,
  input  logic                         instr_valid_i,
  input  ctrl_pkg::decode_t            decode_i,
  input  ctrl_pkg::jump_e              jump_dec_i,
  input  ctrl_pkg::jump_e              jump_id_i,
  input  logic                         branch_taken_i,

  // pipeline status
  input  logic                         id_ready_i,
  input  logic                         ex_valid_i,
  input  logic                         wb_ready_i,
  input  logic                         data_req_ex_i,
  input  logic                         data_misaligned_i,
  input  logic                         mult_multicycle_i,

  // register dependency info
  input  hazard_pkg::wr_en_t           wr_en_i,
  input  hazard_pkg::reg_match_t       match_ex_i,
  input  hazard_pkg::reg_match_t       match_wb_i,
  input  hazard_pkg::reg_match_t       match_alu_i,

  // interrupts and csr writes
  input  ctrl_pkg::irq_t               irq_i,
  input  ctrl_pkg::csr_wr_t            csr_wr_i,

  output logic                         instr_req_o,
  output logic                         busy_o,
  output logic                         pc_set_o,
  output ctrl_pkg::pc_mux_e            pc_mux_o,
  output ctrl_pkg::exc_pc_e            exc_pc_mux_o,
  output logic                         halt_if_o,
  output logic                         halt_id_o,
  output logic                         irq_ack_o,
  output logic [ctrl_pkg::CAUSE_W-1:0] mcause_o,
  output logic                         mie_o,
  output logic                         deassert_we_o,
  output logic                         load_stall_o,
  output logic                         jr_stall_o,
  output logic                         misaligned_stall_o,
  output hazard_pkg::fwd_sel_t         fwd_sel_o
);

  ctrl_pkg::trap_upd_t trap_upd;
  logic                is_decoding;

  // mie_o and jr_stall_o also feed back into the FSM
  ctrl_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_en_i     (fetch_en_i),
    .instr_valid_i  (instr_valid_i),
    .decode_i       (decode_i),
    .jump_dec_i     (jump_dec_i),
    .jump_id_i      (jump_id_i),
    .branch_taken_i (branch_taken_i),
    .id_ready_i     (id_ready_i),
    .ex_valid_i     (ex_valid_i),
    .irq_i          (irq_i),
    .irq_en_i       (mie_o),
    .jr_stall_i     (jr_stall_o),
    .instr_req_o    (instr_req_o),
    .busy_o         (busy_o),
    .pc_set_o       (pc_set_o),
    .pc_mux_o       (pc_mux_o),
    .exc_pc_mux_o   (exc_pc_mux_o),
    .halt_if_o      (halt_if_o),
    .halt_id_o      (halt_id_o),
    .irq_ack_o      (irq_ack_o),
    .is_decoding_o  (is_decoding),
    .trap_upd_o     (trap_upd)
  );

  trap_csr u_csr (
    .clk        (clk),
    .rst_n      (rst_n),
    .csr_wr_i   (csr_wr_i),
    .trap_upd_i (trap_upd),
    .irq_en_o   (mie_o),
    .mcause_o   (mcause_o)
  );

  hazard_unit u_haz (
    .is_decoding_i      (is_decoding),
    .decode_i           (decode_i),
    .jump_dec_i         (jump_dec_i),
    .data_req_ex_i      (data_req_ex_i),
    .wb_ready_i         (wb_ready_i),
    .data_misaligned_i  (data_misaligned_i),
    .wr_en_i            (wr_en_i),
    .match_ex_i         (match_ex_i),
    .match_wb_i         (match_wb_i),
    .match_alu_i        (match_alu_i),
    .load_stall_o       (load_stall_o),
    .jr_stall_o         (jr_stall_o),
    .misaligned_stall_o (misaligned_stall_o),
    .deassert_we_o      (deassert_we_o)
  );

  fwd_unit u_fwd (
    .wr_en_i           (wr_en_i),
    .match_wb_i        (match_wb_i),
    .match_alu_i       (match_alu_i),
    .data_misaligned_i (data_misaligned_i),
    .mult_multicycle_i (mult_multicycle_i),
    .fwd_sel_o         (fwd_sel_o)
  );

endmodule

// File: verification/core_ctrl_chk.sv
`timescale 1ns/1ns

module core_ctrl_chk (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pc_set_i,
  input  ctrl_pkg::pc_mux_e     pc_mux_i,
  input  logic                  irq_ack_i,
  input  ctrl_pkg::ctrl_state_e state_i
);

  // failed assertion count, read by the testbench top
  int assert_fails = 0;

  // a redirect is a single-cycle pulse
  property pc_set_single;
    @(posedge clk) disable iff (!rst_n)
      pc_set_i |=> !pc_set_i;
  endproperty

  // acknowledge only comes with the jump to the vector
  property ack_with_exception;
    @(posedge clk) disable iff (!rst_n)
      irq_ack_i |-> (pc_mux_i == ctrl_pkg::PC_EXCEPTION);
  endproperty

  // nothing is fetched before the core is enabled
  property no_set_in_reset;
    @(posedge clk) disable iff (!rst_n)
      (state_i == ctrl_pkg::RESET) |-> !pc_set_i;
  endproperty

  a_pc_set_single: assert property (pc_set_single)
    else
    begin
      $error("pc_set_o held for two cycles");
      assert_fails++;
    end
  a_ack_with_exception: assert property (ack_with_exception)
    else
    begin
      $error("irq_ack_o without PC_EXCEPTION");
      assert_fails++;
    end
  a_no_set_in_reset: assert property (no_set_in_reset)
    else
    begin
      $error("pc_set_o raised in RESET");
      assert_fails++;
    end

endmodule

bind ctrl_fsm core_ctrl_chk u_chk (
  .clk       (clk),
  .rst_n     (rst_n),
  .pc_set_i  (pc_set_o),
  .pc_mux_i  (pc_mux_o),
  .irq_ack_i (irq_ack_o),
  .state_i   (state_q)
);

// File: verification/ctrl_monitor.sv
`timescale 1ns/1ns

module ctrl_monitor (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       instr_req_i,
  input  logic       busy_i,
  input  logic       pc_set_i,
  input  logic [2:0] pc_mux_i,
  input  logic [1:0] exc_pc_mux_i,
  input  logic       halt_if_i,
  input  logic       halt_id_i,
  input  logic       irq_ack_i,
  input  logic [5:0] mcause_i,
  input  logic       mie_i,
  input  logic       load_stall_i,
  input  logic       jr_stall_i,
  input  logic       misaligned_stall_i,
  input  logic       deassert_we_i,
  input  logic [5:0] fwd_sel_i
);

  int err_count  = 0;
  int test_errs  = 0;
  int test_cnt   = 0;
  int fail_tests = 0;
  int ack_cnt    = 0;
  int ack_base   = 0;

  ////////////////////////////////////////
  // acknowledge pulses seen on the port
  always @(posedge clk)
  begin
    if (rst_n && irq_ack_i)
      ack_cnt <= ack_cnt + 1;
  end

  // current value of a DUT output by port name
  function automatic int sig_val(input string name);
    if (name == "instr_req_o")        return int'(instr_req_i);
    if (name == "busy_o")             return int'(busy_i);
    if (name == "pc_set_o")           return int'(pc_set_i);
    if (name == "pc_mux_o")           return int'(pc_mux_i);
    if (name == "exc_pc_mux_o")       return int'(exc_pc_mux_i);
    if (name == "halt_if_o")          return int'(halt_if_i);
    if (name == "halt_id_o")          return int'(halt_id_i);
    if (name == "irq_ack_o")          return int'(irq_ack_i);
    if (name == "mcause_o")           return int'(mcause_i);
    if (name == "mie_o")              return int'(mie_i);
    if (name == "load_stall_o")       return int'(load_stall_i);
    if (name == "jr_stall_o")         return int'(jr_stall_i);
    if (name == "misaligned_stall_o") return int'(misaligned_stall_i);
    if (name == "deassert_we_o")      return int'(deassert_we_i);
    if (name == "fwd_sel_o")          return int'(fwd_sel_i);
    // unknown name never matches an expected value
    return -1;
  endfunction

  task automatic expect_eq(input string name, input int exp);
    int act;
    act = sig_val(name);
    if (act != exp)
    begin
      $display("Fail t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic note_error(input string msg);
    $display("Error at t=%0t: %s", $time, msg);
    err_count++;
    test_errs++;
  endtask

  task automatic mark_acks();
    ack_base = ack_cnt;
  endtask

  // acknowledges since the last mark
  task automatic check_ack_count(input int exp);
    if ((ack_cnt - ack_base) != exp)
    begin
      $display("Fail t=%0t irq_ack_o pulses expected %0d actual %0d",
               $time, exp, ack_cnt - ack_base);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (test_errs == 0)
      $display("test %0d %s: ok", test_cnt, name);
    else
    begin
      $display("test %0d %s: %0d errors", test_cnt, name, test_errs);
      fail_tests++;
    end
    test_errs = 0;
  endtask

  task automatic report(input int assert_fails);
    $display("tests %0d, failed tests %0d, errors %0d, assertion failures %0d",
             test_cnt, fail_tests, err_count, assert_fails);
  endtask

endmodule

// File: verification/core_ctrl_tb.sv
`timescale 1ns/1ns

module core_ctrl_tb;

  localparam int TIMEOUT  = 50;
  localparam int NO_ACK_N = 20;

  logic                   clk;
  logic                   rst_n;
  logic                   fetch_en, instr_valid, branch_taken;
  logic                   id_ready, ex_valid, wb_ready, data_req_ex;
  logic                   data_misaligned, mult_multicycle;
  ctrl_pkg::decode_t      decode;
  ctrl_pkg::jump_e        jump_dec, jump_id;
  hazard_pkg::wr_en_t     wr_en;
  hazard_pkg::reg_match_t match_ex, match_wb, match_alu;
  ctrl_pkg::irq_t         irq;
  ctrl_pkg::csr_wr_t      csr_wr;

  logic                   instr_req, busy, pc_set, halt_if, halt_id, irq_ack, mie;
  ctrl_pkg::pc_mux_e      pc_mux;
  ctrl_pkg::exc_pc_e      exc_pc_mux;
  logic [5:0]             mcause;
  logic                   deassert_we, load_stall, jr_stall, misaligned_stall;
  hazard_pkg::fwd_sel_t   fwd_sel;

  int                     fd;

  core_ctrl u_dut (
    .clk(clk), .rst_n(rst_n), .fetch_en_i(fetch_en), .instr_valid_i(instr_valid),
    .decode_i(decode), .jump_dec_i(jump_dec), .jump_id_i(jump_id),
    .branch_taken_i(branch_taken), .id_ready_i(id_ready), .ex_valid_i(ex_valid),
    .wb_ready_i(wb_ready), .data_req_ex_i(data_req_ex),
    .data_misaligned_i(data_misaligned), .mult_multicycle_i(mult_multicycle),
    .wr_en_i(wr_en), .match_ex_i(match_ex), .match_wb_i(match_wb),
    .match_alu_i(match_alu), .irq_i(irq), .csr_wr_i(csr_wr),
    .instr_req_o(instr_req), .busy_o(busy), .pc_set_o(pc_set), .pc_mux_o(pc_mux),
    .exc_pc_mux_o(exc_pc_mux), .halt_if_o(halt_if), .halt_id_o(halt_id),
    .irq_ack_o(irq_ack), .mcause_o(mcause), .mie_o(mie),
    .deassert_we_o(deassert_we), .load_stall_o(load_stall), .jr_stall_o(jr_stall),
    .misaligned_stall_o(misaligned_stall), .fwd_sel_o(fwd_sel)
  );

  ctrl_monitor u_mon (
    .clk(clk), .rst_n(rst_n), .instr_req_i(instr_req), .busy_i(busy),
    .pc_set_i(pc_set), .pc_mux_i(pc_mux), .exc_pc_mux_i(exc_pc_mux),
    .halt_if_i(halt_if), .halt_id_i(halt_id), .irq_ack_i(irq_ack),
    .mcause_i(mcause), .mie_i(mie), .load_stall_i(load_stall),
    .jr_stall_i(jr_stall), .misaligned_stall_i(misaligned_stall),
    .deassert_we_i(deassert_we), .fwd_sel_i(fwd_sel)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // hard limit on the whole run
  initial
  begin
    #200000;
    $display("simulation time limit reached");
    $display("CHECKS FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // boot sequence

  task automatic boot_core();
    u_mon.expect_eq("pc_set_o", 0);
    u_mon.expect_eq("irq_ack_o", 0);
    u_mon.expect_eq("halt_if_o", 0);
    u_mon.expect_eq("halt_id_o", 0);
    u_mon.expect_eq("busy_o", 0);
    u_mon.expect_eq("instr_req_o", 0);
    u_mon.expect_eq("mie_o", 0);
    @(posedge clk);
    fetch_en <= 1'b1;
    // one cycle in BOOT_SET with the boot address
    @(posedge clk);
    @(negedge clk);
    u_mon.expect_eq("pc_set_o", 1);
    u_mon.expect_eq("pc_mux_o", 0);
    @(negedge clk);
    u_mon.expect_eq("pc_set_o", 0);
    repeat (2) @(posedge clk);
    u_mon.end_test("boot");
  endtask

  task automatic fwd_vector();
    int we, mwb, malu, mis, mul, exp, r;
    r = $fscanf(fd, "%h %h %h %h %h %h", we, mwb, malu, mis, mul, exp);
    if (r != 6)
      u_mon.note_error("malformed forwarding line in pattern file");
    else
    begin
      @(posedge clk);
      wr_en           <= hazard_pkg::wr_en_t'(we[2:0]);
      match_wb        <= hazard_pkg::reg_match_t'(mwb[2:0]);
      match_alu       <= hazard_pkg::reg_match_t'(malu[2:0]);
      data_misaligned <= mis[0];
      mult_multicycle <= mul[0];
      jump_id         <= ctrl_pkg::jump_e'($urandom_range(0, 3));
      @(negedge clk);
      u_mon.expect_eq("fwd_sel_o", exp);
      u_mon.expect_eq("misaligned_stall_o", mis[0]);
    end
    u_mon.end_test("forwarding vector");
  endtask

  task automatic hazard_vector();
    int vld, jd, dreq, wbr, we, mex, mwb, malu, el, ej, ed, r;
    r = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h",
                vld, jd, dreq, wbr, we, mex, mwb, malu, el, ej, ed);
    if (r != 11)
      u_mon.note_error("malformed hazard line in pattern file");
    else
    begin
      @(posedge clk);
      instr_valid     <= vld[0];
      jump_dec        <= ctrl_pkg::jump_e'(jd[1:0]);
      data_req_ex     <= dreq[0];
      wb_ready        <= wbr[0];
      wr_en           <= hazard_pkg::wr_en_t'(we[2:0]);
      match_ex        <= hazard_pkg::reg_match_t'(mex[2:0]);
      match_wb        <= hazard_pkg::reg_match_t'(mwb[2:0]);
      match_alu       <= hazard_pkg::reg_match_t'(malu[2:0]);
      mult_multicycle <= 1'($urandom_range(0, 1));
      @(negedge clk);
      u_mon.expect_eq("load_stall_o", el);
      u_mon.expect_eq("jr_stall_o", ej);
      u_mon.expect_eq("deassert_we_o", ed);
      // back to an idle decode with no dependencies
      @(posedge clk);
      instr_valid <= 1'b1;
      jump_dec    <= ctrl_pkg::JUMP_NONE;
      wr_en       <= '0;
      data_req_ex <= 1'b0;
      wb_ready    <= 1'b1;
    end
    u_mon.end_test("hazard vector");
  endtask

  // kind 1 illegal, 2 ecall, 3 mret
  task automatic trap_sequence(input int kind, input int e_mux, input int e_exc,
                               input int e_cause, input int e_mie);
    ctrl_pkg::decode_t d;
    int                n;
    d         = '0;
    d.illegal = (kind == 1);
    d.ecall   = (kind == 2);
    d.mret    = (kind == 3);
    @(posedge clk);
    decode   <= d;
    ex_valid <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    u_mon.expect_eq("halt_id_o", 1);
    // EX drains after a variable delay
    repeat ($urandom_range(1, 4)) @(posedge clk);
    ex_valid <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!pc_set && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (!pc_set)
      u_mon.note_error("no pc_set after the trap instruction");
    else
    begin
      u_mon.expect_eq("pc_mux_o", e_mux);
      if (kind < 3)
        u_mon.expect_eq("exc_pc_mux_o", e_exc);
    end
    @(posedge clk);
    decode <= '0;
    @(negedge clk);
    if (kind < 3)
      u_mon.expect_eq("mcause_o", e_cause);
    u_mon.expect_eq("mie_o", e_mie);
  endtask

  task automatic exception_case();
    int kind, e_mux, e_exc, e_cause, e_mie, r;
    r = $fscanf(fd, "%h %h %h %h %h", kind, e_mux, e_exc, e_cause, e_mie);
    if (r != 5)
      u_mon.note_error("malformed trap line in pattern file");
    else
      trap_sequence(kind, e_mux, e_exc, e_cause, e_mie);
    u_mon.end_test("exception or mret");
  endtask

  task automatic interrupt_case();
    int en, id, e_ack, n, r;
    r = $fscanf(fd, "%h %h %h", en, id, e_ack);
    if (r != 3)
      u_mon.note_error("malformed interrupt line in pattern file");
    else
    begin
      @(posedge clk);
      csr_wr <= ctrl_pkg::csr_wr_t'({1'b1, en[0]});
      @(posedge clk);
      csr_wr <= '0;
      irq    <= ctrl_pkg::irq_t'({1'b1, id[4:0]});
      u_mon.mark_acks();
      n = 0;
      @(negedge clk);
      while (!irq_ack && n < ((e_ack != 0) ? TIMEOUT : NO_ACK_N))
      begin
        @(negedge clk);
        n++;
      end
      if (e_ack != 0 && !irq_ack)
        u_mon.note_error("interrupt was never acknowledged");
      else if (e_ack == 0 && irq_ack)
        u_mon.note_error("masked interrupt was acknowledged");
      if (irq_ack)
        u_mon.expect_eq("pc_mux_o", 4);
      // source drops the request after seeing the ack
      @(posedge clk);
      irq <= '0;
      @(negedge clk);
      repeat ($urandom_range(1, 3)) @(negedge clk);
      u_mon.check_ack_count(e_ack);
      if (e_ack != 0)
      begin
        u_mon.expect_eq("mcause_o", 32 + id[4:0]);
        u_mon.expect_eq("mie_o", 0);
        // handler returns and mpie goes back to mie
        trap_sequence(3, 5, 0, 0, 1);
      end
    end
    u_mon.end_test("interrupt");
  endtask

  initial
  begin
    logic [7:0]       tag;
    logic [8*160-1:0] line;
    int               r;
    bit               done;
    void'($urandom(32'hef0f));
    rst_n           <= 1'b0;
    fetch_en        <= 1'b0;
    instr_valid     <= 1'b1;
    decode          <= '0;
    jump_dec        <= ctrl_pkg::JUMP_NONE;
    jump_id         <= ctrl_pkg::JUMP_NONE;
    branch_taken    <= 1'b0;
    id_ready        <= 1'b1;
    ex_valid        <= 1'b1;
    wb_ready        <= 1'b1;
    data_req_ex     <= 1'b0;
    data_misaligned <= 1'b0;
    mult_multicycle <= 1'b0;
    wr_en           <= '0;
    match_ex        <= '0;
    match_wb        <= '0;
    match_alu       <= '0;
    irq             <= '0;
    csr_wr          <= '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    boot_core();
    done = 1'b0;
    fd = $fopen("verification/ctrl_patterns.txt", "r");
    if (fd == 0)
    begin
      u_mon.note_error("pattern file could not be opened");
      done = 1'b1;
    end
    while (!done)
    begin
      r = $fscanf(fd, " %c", tag);
      if (r != 1)
        done = 1'b1;
      else if (tag == "#")
        r = $fgets(line, fd);
      else if (tag == "F")
        fwd_vector();
      else if (tag == "H")
        hazard_vector();
      else if (tag == "X")
        exception_case();
      else if (tag == "I")
        interrupt_case();
      else
      begin
        u_mon.note_error("unknown tag in pattern file");
        done = 1'b1;
      end
    end
    repeat (4) @(posedge clk);
    u_mon.report(u_dut.u_fsm.u_chk.assert_fails);
    if (u_mon.err_count == 0 && u_dut.u_fsm.u_chk.assert_fails == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: verification/ctrl_patterns.txt
# F wr_en match_wb match_alu misaligned multicycle | exp fwd_sel  H valid jump_dec data_req
# wb_ready wr_en match_ex match_wb match_alu | exp load jr dwe  X kind mux exc cause mie  I mie id ack
F 0 7 7 0 0 00
F 2 7 7 0 0 2a
F 3 7 5 0 0 19
F 1 0 2 0 0 04
F 2 4 0 1 0 10
F 2 7 0 1 1 12
F 2 7 0 0 1 29
F 3 1 6 0 0 16
H 1 0 0 1 0 0 0 0 0 0 0
H 1 0 1 1 4 4 0 0 1 0 1
H 1 0 0 0 2 0 1 0 1 0 1
H 1 0 0 1 2 0 1 0 0 0 0
H 1 2 0 1 1 0 0 4 0 1 1
H 1 2 0 1 1 0 0 3 0 0 0
H 0 0 0 1 0 0 0 0 0 0 1
H 1 2 1 1 4 4 0 0 1 1 1
X 1 4 0 02 0
X 2 4 1 0b 0
X 3 5 0 00 0
I 1 05 1
I 1 1a 1
I 0 0c 0

// File: tb.f
rtl/ctrl_pkg.sv
rtl/hazard_pkg.sv
rtl/trap_csr.sv
rtl/hazard_unit.sv
rtl/fwd_unit.sv
rtl/ctrl_fsm.sv
rtl/core_ctrl.sv
verification/core_ctrl_chk.sv
verification/ctrl_monitor.sv
verification/core_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the core controller testbench

VERILATOR ?= verilator
TOP       ?= core_ctrl_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
